// ==== design/rdlat_pkg.sv ====
// shared widths for the DDR read-return path
// latency setting, history depth, beat and AFI word widths, command length field
`default_nettype none

package rdlat_pkg;

	// width of the calibrated read latency setting
	// the setting is static during a read and is only changed while the path is idle
	localparam int MAX_LATENCY_COUNT_WIDTH = 5;

	// one history tap per possible latency value
	// tap k of the history marks a beat strobe issued k+1 cycles earlier
	localparam int LATENCY_NUM = 2 ** MAX_LATENCY_COUNT_WIDTH;

	// one memory beat on the DQ bus
	localparam int BEAT_WIDTH = 16;

	// half-rate AFI word, which carries two memory beats
	// the even beat sits in the low half and the odd beat in the high half
	localparam int AFI_WIDTH = 2 * BEAT_WIDTH;

	// command length field, a value n requests n+1 AFI words
	// so a command always covers an even number of beats, 2(n+1) in total
	localparam int LEN_WIDTH = 2;

endpackage

`default_nettype wire

// ==== design/rd_burst_decode.sv ====
// read command burst decoder
// turns each command into one registered strobe per memory beat,
// reports the busy level and keeps the strobe history for the latency select
`timescale 1ns/1ps
`default_nettype none

module rd_burst_decode
(
	input  wire                                pll_afi_clk,
	input  wire                                reset_n,
	input  wire                                cmd_valid,
	input  wire [rdlat_pkg::LEN_WIDTH-1:0]     cmd_len,
	output logic                               cmd_busy,
	output logic [rdlat_pkg::LATENCY_NUM-1:0]  latency_shifter
);

	// the counter holds the beats still to issue after the current strobe
	// a command of length n needs 2(n+1) strobes, so one strobe goes out with the load
	// and 2n+1 remain, which is {cmd_len, 1'b1} and never exceeds 7 for a 2-bit length
	logic [rdlat_pkg::LEN_WIDTH:0] beats_left;

	// registered beat strobe, high once per beat from the cycle after cmd_valid
	logic beat_strobe;

	// beat counter and strobe
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			beats_left  <= '0;
			beat_strobe <= 1'b0;
		end
		else if (cmd_valid)
		begin
			// first beat goes out on the next cycle and the rest follow back to back
			beats_left  <= {cmd_len, 1'b1};
			beat_strobe <= 1'b1;
		end
		else if (beats_left != '0)
		begin
			beats_left  <= beats_left - 1'b1;
			beat_strobe <= 1'b1;
		end
		else
		begin
			beat_strobe <= 1'b0;
		end
	end

	// busy drops in the cycle that carries the last strobe of the burst,
	// so a new command may be accepted there and its beats continue without a gap
	assign cmd_busy = (beats_left != '0);

	// strobe history
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			latency_shifter <= '0;
		end
		else
		begin
			// bit 0 takes the registered strobe, so bit k is k+1 cycles old
			// several commands may sit in the history at once when latency is long
			latency_shifter <= {latency_shifter[rdlat_pkg::LATENCY_NUM-2:0], beat_strobe};
		end
	end

	// the controller only issues a command while the previous burst is done
	// a command during busy would reload the counter and drop beats of the open burst
	a_no_cmd_while_busy : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n)
		cmd_valid |-> !cmd_busy
	) else $error("cmd_valid seen while cmd_busy is high");

endmodule

`default_nettype wire

// ==== design/read_valid_selector.sv ====
// read valid selector
// decodes the calibrated latency to a one-hot tap select and raises
// read_enable and read_valid when a beat strobe reaches the selected tap
`timescale 1ns/1ps
`default_nettype none

module read_valid_selector
(
	input  wire                                          pll_afi_clk,
	input  wire                                          reset_n,
	input  wire [rdlat_pkg::LATENCY_NUM-1:0]             latency_shifter,
	input  wire [rdlat_pkg::MAX_LATENCY_COUNT_WIDTH-1:0] latency_counter,
	output logic                                         read_enable,
	output logic                                         read_valid
);

	// one-hot decode of the latency setting, and its registered copy
	logic [rdlat_pkg::LATENCY_NUM-1:0] selector;
	logic [rdlat_pkg::LATENCY_NUM-1:0] selector_reg;

	// history bits that line up with the selected tap
	logic [rdlat_pkg::LATENCY_NUM-1:0] valid_select;

	// latency decode, exactly one bit set for every setting
	always_comb
	begin
		selector = '0;
		for (int i = 0; i < rdlat_pkg::LATENCY_NUM; i++)
		begin
			if (latency_counter == i[rdlat_pkg::MAX_LATENCY_COUNT_WIDTH-1:0])
				selector[i] = 1'b1;
		end
	end

	// the setting is a slow level, registering it keeps the decode off the data timing
	// this is why one idle cycle has to pass after a latency change
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
			selector_reg <= '0;
		else
			selector_reg <= selector;
	end

	assign valid_select = selector_reg & latency_shifter;

	// a strobe at cycle s sits in tap c at s+c+1 and shows here at s+c+2
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			read_enable <= 1'b0;
			read_valid  <= 1'b0;
		end
		else
		begin
			read_enable <= |valid_select;
			read_valid  <= |valid_select;
		end
	end

	// after the first clock out of reset the select always names exactly one tap
	a_selector_onehot : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n)
		$past(reset_n) |-> $onehot(selector_reg)
	) else $error("latency selector is not one-hot");

	a_enable_eq_valid : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n)
		read_enable == read_valid
	) else $error("read_enable and read_valid disagree");

endmodule

`default_nettype wire

// ==== design/rd_return_assembler.sv ====
// read return assembler
// captures returning beats on read_enable and packs each even/odd pair
// into one AFI word with a single-cycle valid
`timescale 1ns/1ps
`default_nettype none

module rd_return_assembler
(
	input  wire                               pll_afi_clk,
	input  wire                               reset_n,
	input  wire                               read_enable,
	input  wire [rdlat_pkg::BEAT_WIDTH-1:0]   rdata_in,
	output logic                              afi_rdata_valid,
	output logic [rdlat_pkg::AFI_WIDTH-1:0]   afi_rdata
);

	// low when the next beat is even, high when it is odd
	// every command has an even beat count, so parity realigns at each command
	logic beat_odd;

	// the even beat waits here until its odd partner arrives
	logic [rdlat_pkg::BEAT_WIDTH-1:0] hold_lo;

	// beat parity
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
			beat_odd <= 1'b0;
		else if (read_enable)
			beat_odd <= ~beat_odd;
	end

	// word valid follows the odd beat by one cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
			afi_rdata_valid <= 1'b0;
		else
			afi_rdata_valid <= read_enable & beat_odd;
	end

	// data path
	always_ff @(posedge pll_afi_clk)
	begin
		// even beat goes to the holding register
		if (read_enable && !beat_odd)
			hold_lo <= rdata_in;

		// the odd beat completes the word with the low beat first
		// the word then stays on afi_rdata until the next pair is done
		if (read_enable && beat_odd)
			afi_rdata <= {rdata_in, hold_lo};
	end

	// words are at least two beats apart, so valid can never stay high
	a_valid_single_pulse : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n)
		afi_rdata_valid |=> !afi_rdata_valid
	) else $error("afi_rdata_valid high on consecutive cycles");

endmodule

`default_nettype wire

// ==== design/rdlat_top.sv ====
// top level of the DDR read-return path
// burst decoder, read valid selector and return assembler on plain ports
`timescale 1ns/1ps
`default_nettype none

module rdlat_top
(
	input  wire                                          pll_afi_clk,
	input  wire                                          reset_n,

	// read command from the controller
	input  wire                                          cmd_valid,
	input  wire [rdlat_pkg::LEN_WIDTH-1:0]               cmd_len,
	output wire                                          cmd_busy,

	// calibrated read latency, static while reads are outstanding
	input  wire [rdlat_pkg::MAX_LATENCY_COUNT_WIDTH-1:0] latency_counter,

	// beat data from the memory side, aligned to the internal read_enable
	input  wire [rdlat_pkg::BEAT_WIDTH-1:0]              rdata_in,

	// returned data toward the controller
	output wire                                          read_valid,
	output wire                                          afi_rdata_valid,
	output wire [rdlat_pkg::AFI_WIDTH-1:0]               afi_rdata
);

	// beat strobe history from the decoder
	wire [rdlat_pkg::LATENCY_NUM-1:0] latency_shifter;

	// beat capture strobe into the assembler
	wire read_enable;

	rd_burst_decode u_decode
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.cmd_valid       (cmd_valid),
		.cmd_len         (cmd_len),
		.cmd_busy        (cmd_busy),
		.latency_shifter (latency_shifter)
	);

	read_valid_selector u_select
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.latency_shifter (latency_shifter),
		.latency_counter (latency_counter),
		.read_enable     (read_enable),
		.read_valid      (read_valid)
	);

	rd_return_assembler u_assemble
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.read_enable     (read_enable),
		.rdata_in        (rdata_in),
		.afi_rdata_valid (afi_rdata_valid),
		.afi_rdata       (afi_rdata)
	);

endmodule

`default_nettype wire

// ==== sim/rdlat_tb.sv ====
// testbench for the DDR read-return path
// xorshift stimulus, a memory model that answers at the set latency,
// a reference packing function, compare tasks and a cycle timeout
`timescale 1ns/1ps
`default_nettype none

module rdlat_tb;

	localparam int RESET_CYCLES = 16;
	localparam int MAX_GAP = 3;
	localparam int CMDS_PER_LATENCY = 3;
	localparam int RANDOM_CMDS = 40;

	// one first-return command, a group per latency, one command per length and random traffic
	localparam int NUM_CMDS = 1 + rdlat_pkg::LATENCY_NUM * CMDS_PER_LATENCY + 4 + RANDOM_CMDS;

	// each command may take its beats, a gap and the longest latency, plus reset and flushes
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * rdlat_pkg::LATENCY_NUM
		+ NUM_CMDS * (8 + MAX_GAP + rdlat_pkg::LATENCY_NUM);

	logic                                          pll_afi_clk;
	logic                                          reset_n;
	logic                                          cmd_valid;
	logic [rdlat_pkg::LEN_WIDTH-1:0]               cmd_len;
	logic [rdlat_pkg::MAX_LATENCY_COUNT_WIDTH-1:0] latency_counter;
	logic [rdlat_pkg::BEAT_WIDTH-1:0]              rdata_in = '0;
	wire                                           cmd_busy;
	wire                                           read_valid;
	wire                                           afi_rdata_valid;
	wire  [rdlat_pkg::AFI_WIDTH-1:0]               afi_rdata;

	// cycle number advanced on every rising edge
	int cyc = 0;
	logic [31:0] rng_state = 32'd1317;
	int cur_latency = 0;

	// predicted busy window of the latest command
	int busy_from = 0;
	int busy_until = -1;

	// every beat of the strobe record is due at s+c+2 and every word one cycle after its odd beat
	int                               mem_due[$];
	logic [rdlat_pkg::BEAT_WIDTH-1:0] mem_data[$];
	int                               rv_due[$];
	int                               word_due[$];
	logic [rdlat_pkg::AFI_WIDTH-1:0]  exp_words[$];

	// running totals kept by the comparing process that each group measures against a base
	int rv_total = 0;
	int word_total = 0;
	int first_rv_cycle = -1;
	int first_word_cycle = -1;
	int rv_base = 0;
	int word_base = 0;
	int group_issue = -1;
	int max_pending = 0;
	logic [31:0] filler;

	rdlat_top u_rdlat_top
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.cmd_valid       (cmd_valid),
		.cmd_len         (cmd_len),
		.cmd_busy        (cmd_busy),
		.latency_counter (latency_counter),
		.rdata_in        (rdata_in),
		.read_valid      (read_valid),
		.afi_rdata_valid (afi_rdata_valid),
		.afi_rdata       (afi_rdata)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #20 pll_afi_clk = ~pll_afi_clk;
	end

	always @(posedge pll_afi_clk)
		cyc <= cyc + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int next_random(input int bound);
		rng_state = xorshift32(rng_state);
		return int'(rng_state % bound);
	endfunction

	// expected AFI word with the even beat in the low half
	function automatic logic [rdlat_pkg::AFI_WIDTH-1:0] pack_word(
		input logic [rdlat_pkg::BEAT_WIDTH-1:0] lo_beat,
		input logic [rdlat_pkg::BEAT_WIDTH-1:0] hi_beat);
		return {hi_beat, lo_beat};
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "testbench stopped on first error");
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("[ERROR] time %0t %s expected %b actual %b",
				$time, name, expected, actual));
	endtask

	task automatic compare_word(input string name,
		input logic [rdlat_pkg::AFI_WIDTH-1:0] expected,
		input logic [rdlat_pkg::AFI_WIDTH-1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("[ERROR] time %0t %s expected %h actual %h",
				$time, name, expected, actual));
	endtask

	task automatic compare_count(input string name, input int expected, input int actual);
		if (actual != expected)
			abort_run($sformatf("[ERROR] time %0t %s expected %0d actual %0d",
				$time, name, expected, actual));
	endtask

	// the run must not outlast the budget worked out from the command count
	always @(posedge pll_afi_clk)
	begin
		if (cyc >= TIMEOUT_CYCLES)
			abort_run($sformatf("run hung, still busy after %0d cycles", cyc));
	end

	// the memory model presents a beat in the very cycle its read_enable is high
	// other cycles carry a filler so a misaligned capture shows up as bad data
	always @(posedge pll_afi_clk)
	begin
		filler = cyc * 32'h9e3779b1;
		if (mem_due.size() != 0 && mem_due[0] == cyc + 1)
		begin
			rdata_in <= mem_data.pop_front();
			mem_due.delete(0);
		end
		else
			rdata_in <= filler[31:16];
	end

	// the comparing process samples at the falling edge where outputs are stable
	always @(negedge pll_afi_clk)
	begin
		logic exp_rv;
		logic exp_busy;
		logic exp_av;
		if (reset_n)
		begin
			exp_rv = (rv_due.size() != 0 && rv_due[0] == cyc);
			if (exp_rv)
				rv_due.delete(0);
			compare_bit("read_valid", exp_rv, read_valid);
			if (read_valid)
			begin
				if (rv_total == 0)
					first_rv_cycle = cyc;
				rv_total++;
			end

			exp_busy = (cyc >= busy_from && cyc <= busy_until);
			compare_bit("cmd_busy", exp_busy, cmd_busy);

			exp_av = (word_due.size() != 0 && word_due[0] == cyc);
			if (exp_av)
				word_due.delete(0);
			compare_bit("afi_rdata_valid", exp_av, afi_rdata_valid);
			if (afi_rdata_valid)
			begin
				if (word_total == 0)
					first_word_cycle = cyc;
				word_total++;
				compare_word("afi_rdata", exp_words.pop_front(), afi_rdata);
			end
		end
	end

	// waits out the gap and the busy window, then sends one command and records its beats
	task automatic send_cmd(input int len, input int gap);
		logic [31:0] len_bits;
		logic [rdlat_pkg::BEAT_WIDTH-1:0] lo_beat;
		logic [rdlat_pkg::BEAT_WIDTH-1:0] beat;
		int t;
		int due;
		len_bits = len;
		lo_beat = '0;
		repeat (gap) @(posedge pll_afi_clk);
		@(posedge pll_afi_clk);
		// the cycle about to start is cyc+1 and it may carry cmd_valid once busy is over
		while (cyc + 1 <= busy_until)
			@(posedge pll_afi_clk);
		t = cyc + 1;
		cmd_valid <= 1'b1;
		cmd_len <= len_bits[rdlat_pkg::LEN_WIDTH-1:0];
		busy_from = t + 1;
		busy_until = t + 2 * len + 1;
		if (group_issue < 0)
			group_issue = t;
		for (int i = 0; i < 2 * (len + 1); i++)
		begin
			rng_state = xorshift32(rng_state);
			beat = rng_state[rdlat_pkg::BEAT_WIDTH-1:0];
			// beat strobe i is high at t+1+i and returns c+2 cycles later
			due = t + 1 + i + cur_latency + 2;
			mem_due.push_back(due);
			mem_data.push_back(beat);
			rv_due.push_back(due);
			if (i % 2 == 0)
				lo_beat = beat;
			else
			begin
				word_due.push_back(due + 1);
				exp_words.push_back(pack_word(lo_beat, beat));
			end
		end
		if (exp_words.size() > max_pending)
			max_pending = exp_words.size();
		@(posedge pll_afi_clk);
		cmd_valid <= 1'b0;
	endtask

	task automatic set_latency(input int c);
		logic [31:0] c_bits;
		c_bits = c;
		// old strobes have to leave the whole history before the tap moves
		repeat (rdlat_pkg::LATENCY_NUM + 1) @(posedge pll_afi_clk);
		latency_counter <= c_bits[rdlat_pkg::MAX_LATENCY_COUNT_WIDTH-1:0];
		cur_latency = c;
		// idle cycle so the registered selector picks up the new setting
		@(posedge pll_afi_clk);
	endtask

	task automatic start_group;
		rv_base = rv_total;
		word_base = word_total;
		group_issue = -1;
	endtask

	task automatic drain;
		while (rv_due.size() != 0 || word_due.size() != 0 || mem_due.size() != 0)
			@(posedge pll_afi_clk);
		@(posedge pll_afi_clk);
	endtask

	initial
	begin
		int len;
		int gap;
		int beats;
		reset_n <= 1'b0;
		cmd_valid <= 1'b0;
		cmd_len <= '0;
		latency_counter <= '0;
		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		reset_n <= 1'b1;

		// the comparing process expects every output low while idle after reset
		repeat (16) @(posedge pll_afi_clk);

		// a single command at latency 0 returns its first beat at cycle 3 and word at cycle 5
		set_latency(0);
		start_group();
		send_cmd(1, 0);
		drain();
		compare_count("cycles to first read_valid", 3, first_rv_cycle - group_issue);
		compare_count("cycles to first afi_rdata_valid", 5, first_word_cycle - group_issue);

		// every latency setting gets a group whose pulse count is checked
		for (int c = 0; c < rdlat_pkg::LATENCY_NUM; c++)
		begin
			set_latency(c);
			start_group();
			beats = 0;
			for (int k = 0; k < CMDS_PER_LATENCY; k++)
			begin
				len = next_random(4);
				gap = next_random(MAX_GAP + 1);
				send_cmd(len, gap);
				beats += 2 * (len + 1);
			end
			drain();
			compare_count("read_valid pulses", beats, rv_total - rv_base);
			compare_count("afi words", beats / 2, word_total - word_base);
		end

		// each command length on its own
		set_latency(7);
		for (int n = 0; n < 4; n++)
		begin
			start_group();
			send_cmd(n, 0);
			drain();
			compare_count("afi words of one command", n + 1, word_total - word_base);
		end

		// back to back traffic at a long latency keeps several commands in the history
		set_latency(24 + next_random(8));
		start_group();
		max_pending = 0;
		beats = 0;
		for (int k = 0; k < RANDOM_CMDS; k++)
		begin
			len = next_random(4);
			gap = (next_random(4) == 0) ? next_random(MAX_GAP + 1) : 0;
			send_cmd(len, gap);
			beats += 2 * (len + 1);
		end
		drain();
		compare_count("read_valid pulses", beats, rv_total - rv_base);
		compare_count("afi words", beats / 2, word_total - word_base);
		// one command has at most four words so more pending means overlap
		if (max_pending <= 4)
			abort_run("random traffic never had two commands in flight");

		if (exp_words.size() == 0 && rv_due.size() == 0)
		begin
			$display(">>> PASS");
			$finish;
		end
		else
			abort_run("expected words still outstanding at the end of the run");
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/rdlat_pkg.sv
design/rd_burst_decode.sv
design/read_valid_selector.sv
design/rd_return_assembler.sv
design/rdlat_top.sv
sim/rdlat_tb.sv

// ==== Makefile ====
# Verilator build and run for the DDR read-return path

VERILATOR ?= verilator
TOP       ?= rdlat_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(shell grep -E '\.s?v$$' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)
